/* filelist.f */
common/gb_shell_pkg.sv
verilog/host_config_regs.sv
download/download_decode.sv
download/palette_store.sv
verilog/model_select.sv
verilog/ff_latch.sv
verilog/av_output.sv
verilog/gb_core_top.sv
tb/gb_core_chk.sv
tb/tb_gb_core_top.sv

/* Makefile */
# Verilator flow for the console host glue testbench

TOP := tb_gb_core_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

/* tb/tb_gb_core_top.sv */
// Directed testbench for the console host glue.
// Runs the full host reset hold and one press past the tap limit,
// so a run covers several million clk_sys cycles.
// Inputs change on the falling edge and outputs are read there too.

`timescale 1ns/100ps

module tb_gb_core_top
    import gb_shell_pkg::*;
();

    logic        clk_sys;
    logic        reset;
    logic        bridge_wr;
    logic [31:0] bridge_addr;
    logic [31:0] bridge_wr_data;
    logic        dataslot_requestwrite;
    logic [15:0] dataslot_requestwrite_id;
    logic        dataslot_allcomplete;
    logic        ioctl_wr;
    logic [15:0] ioctl_dout;
    logic        is_gbc_game;
    logic [31:0] cont1_key;
    logic [15:0] audio_in_l;
    logic [15:0] audio_in_r;
    logic [23:0] rgb_in;
    logic        hs_in;
    logic        vs_in;
    logic        hblank;
    logic        vblank;
    logic        core_reset;
    logic        download_active;
    logic [2:0]  mapper_sel;
    logic [95:0] palette;
    logic        is_gbc;
    logic        megaduck;
    logic        fast_forward;
    logic [15:0] audio_out_l;
    logic [15:0] audio_out_r;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;

    int err_count;
    int test_count;
    int failed_tests;

    gb_core_top i_gb_core_top (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    ////////////////////
    // helpers
    ////////////////////
    task automatic tick(input int n);
        repeat (n) @(negedge clk_sys);
    endtask

    task automatic value_error(input string test, input string what,
                               input string expected, input string actual);
        $display("error in %s, %s expected %s actual %s", test, what, expected, actual);
        err_count++;
    endtask

    task automatic failure(input string test, input string msg);
        $display("%s: %s", test, msg);
        err_count++;
    endtask

    task automatic finish_test(input string test, input int start);
        test_count++;
        if (err_count != start) begin
            failed_tests++;
            $display("test %s failed", test);
        end else begin
            $display("test %s passed", test);
        end
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        tick(1);
        bridge_wr = 1'b0;
    endtask

    task automatic begin_download(input logic [15:0] id);
        dataslot_requestwrite_id = id;
        dataslot_requestwrite    = 1'b1;
        tick(1);
        dataslot_requestwrite = 1'b0;
    endtask

    task automatic end_download();
        dataslot_allcomplete = 1'b1;
        tick(1);
        dataslot_allcomplete = 1'b0;
    endtask

    // one full download window, then the latched model
    task automatic run_download(input string test, input logic [15:0] id,
                                input logic exp_gbc, input logic exp_md);
        begin_download(id);
        if (!download_active) begin
            failure(test, "download_active did not rise after requestwrite");
        end
        // every id used here is a cart, so the core must sit in reset
        if (core_reset !== 1'b1) begin
            value_error(test, "core_reset", "1", $sformatf("%b", core_reset));
        end
        tick(2);
        end_download();
        if (download_active) begin
            failure(test, "download_active still high after allcomplete");
        end
        if (is_gbc !== exp_gbc) begin
            value_error(test, $sformatf("is_gbc for id %h", id),
                        $sformatf("%b", exp_gbc), $sformatf("%b", is_gbc));
        end
        if (megaduck !== exp_md) begin
            value_error(test, $sformatf("megaduck for id %h", id),
                        $sformatf("%b", exp_md), $sformatf("%b", megaduck));
        end
    endtask

    task automatic tap_ff(input int cycles);
        cont1_key[9] = 1'b1;
        tick(cycles);
        cont1_key[9] = 1'b0;
        // release edge, then one cycle for the registered output
        tick(3);
    endtask

    task automatic check_audio(input string test, input logic muted);
        logic [31:0] r;
        logic [15:0] exp_l;
        logic [15:0] exp_r;
        r = $urandom;
        audio_in_l = r[15:0];
        audio_in_r = r[31:16];
        exp_l = muted ? 16'd0 : r[15:0];
        exp_r = muted ? 16'd0 : r[31:16];
        tick(1);
        if (audio_out_l !== exp_l) begin
            value_error(test, "audio_out_l", $sformatf("%h", exp_l),
                        $sformatf("%h", audio_out_l));
        end
        if (audio_out_r !== exp_r) begin
            value_error(test, "audio_out_r", $sformatf("%h", exp_r),
                        $sformatf("%h", audio_out_r));
        end
    endtask

    // caller raises the sync input, then this looks for the single pulse
    task automatic measure_pulse(input string test, input logic sel_hs, input int exp_delay);
        int   n;
        int   extra;
        logic seen;
        n = 0;
        extra = 0;
        seen = 1'b0;
        while (!seen && n < 32) begin
            tick(1);
            n++;
            seen = sel_hs ? video_hs : video_vs;
        end
        if (!seen) begin
            failure(test, "no sync pulse within 32 cycles");
        end else if (n != exp_delay) begin
            value_error(test, "sync pulse delay", $sformatf("%0d", exp_delay),
                        $sformatf("%0d", n));
        end
        repeat (12) begin
            tick(1);
            if (sel_hs ? video_hs : video_vs) begin
                extra++;
            end
        end
        if (extra != 0) begin
            failure(test, "sync pulse lasted more than one cycle or repeated");
        end
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic test_settings();
        string name;
        int    start;
        name = "settings";
        start = err_count;
        bridge_write(ADDR_MAPPER_SEL, 32'd5);
        if (mapper_sel !== 3'd5) begin
            value_error(name, "mapper_sel", "5", $sformatf("%0d", mapper_sel));
        end
        // 0x204 sits between mapped words
        bridge_write(32'h0000_0204, 32'd3);
        if (mapper_sel !== 3'd5) begin
            value_error(name, "mapper_sel after unmapped write", "5",
                        $sformatf("%0d", mapper_sel));
        end
        finish_test(name, start);
    endtask

    task automatic test_host_reset();
        string name;
        int    start;
        int    n;
        name = "host_reset";
        start = err_count;
        if (core_reset !== 1'b0) begin
            value_error(name, "core_reset before write", "0", $sformatf("%b", core_reset));
        end
        bridge_write(ADDR_HOST_RESET, 32'd1);
        if (core_reset !== 1'b1) begin
            value_error(name, "core_reset after write", "1", $sformatf("%b", core_reset));
        end
        n = 0;
        while (core_reset && n < RESET_HOLD_CYCLES + 64) begin
            tick(1);
            n++;
        end
        if (core_reset) begin
            failure(name, "core_reset never dropped after the host reset hold");
        end else if (n != RESET_HOLD_CYCLES) begin
            value_error(name, "host reset length", $sformatf("%0d", RESET_HOLD_CYCLES),
                        $sformatf("%0d", n));
        end
        finish_test(name, start);
    endtask

    task automatic test_palette();
        string        name;
        int           start;
        logic [127:0] exp_pal;
        logic [31:0]  r;
        logic [15:0]  w;
        name = "palette";
        start = err_count;
        exp_pal = PALETTE_DEFAULT;
        if (palette !== exp_pal[127:32]) begin
            value_error(name, "default palette", $sformatf("%h", exp_pal[127:32]),
                        $sformatf("%h", palette));
        end
        begin_download(SLOT_PALETTE);
        if (core_reset !== 1'b0) begin
            value_error(name, "core_reset", "0", $sformatf("%b", core_reset));
        end
        for (int i = 0; i < 8; i++) begin
            r = $urandom;
            w = r[15:0];
            ioctl_dout = w;
            ioctl_wr   = 1'b1;
            exp_pal = {exp_pal[111:0], w[7:0], w[15:8]};
            tick(1);
        end
        ioctl_wr = 1'b0;
        end_download();
        if (palette !== exp_pal[127:32]) begin
            value_error(name, "loaded palette", $sformatf("%h", exp_pal[127:32]),
                        $sformatf("%h", palette));
        end
        finish_test(name, start);
    endtask

    task automatic test_download_model();
        string name;
        int    start;
        name = "download_model";
        start = err_count;
        // auto model, kind 1 flavour 0 reads as colour
        is_gbc_game = 1'b0;
        run_download(name, 16'h0001, 1'b1, 1'b0);
        // kind 0 with flavour 2, model comes from the game flag
        is_gbc_game = 1'b1;
        run_download(name, 16'h0080, 1'b1, 1'b0);
        is_gbc_game = 1'b0;
        run_download(name, 16'h0080, 1'b0, 1'b0);
        // megaduck slot is kind 1 flavour 2
        run_download(name, 16'h0081, 1'b0, 1'b1);
        // forced colour overrides the game flag
        bridge_write(ADDR_SYS_TYPE, {30'd0, SYS_GBC});
        run_download(name, 16'h0080, 1'b1, 1'b0);
        finish_test(name, start);
    endtask

    task automatic test_ff_tap();
        string name;
        int    start;
        name = "ff_tap";
        start = err_count;
        tap_ff(10);
        if (fast_forward !== 1'b1) begin
            value_error(name, "fast_forward after tap", "1", $sformatf("%b", fast_forward));
        end
        cont1_key[9] = 1'b1;
        tick(10);
        if (fast_forward !== 1'b1) begin
            value_error(name, "fast_forward while held", "1", $sformatf("%b", fast_forward));
        end
        cont1_key[9] = 1'b0;
        tick(3);
        if (fast_forward !== 1'b0) begin
            value_error(name, "fast_forward after second press", "0",
                        $sformatf("%b", fast_forward));
        end
        finish_test(name, start);
    endtask

    task automatic test_ff_hold();
        string name;
        int    start;
        name = "ff_hold";
        start = err_count;
        cont1_key[9] = 1'b1;
        tick(FF_TAP_CYCLES + 32'd4);
        if (fast_forward !== 1'b1) begin
            value_error(name, "fast_forward while held", "1", $sformatf("%b", fast_forward));
        end
        cont1_key[9] = 1'b0;
        tick(3);
        if (fast_forward !== 1'b0) begin
            value_error(name, "fast_forward after long press", "0",
                        $sformatf("%b", fast_forward));
        end
        finish_test(name, start);
    endtask

    task automatic test_audio_mute();
        string name;
        int    start;
        name = "audio_mute";
        start = err_count;
        repeat (4) check_audio(name, 1'b0);
        tap_ff(10);
        if (fast_forward !== 1'b1) begin
            failure(name, "fast forward did not latch for the mute check");
        end
        repeat (4) check_audio(name, 1'b1);
        bridge_write(ADDR_FF_SND_EN, 32'd1);
        repeat (4) check_audio(name, 1'b0);
        // second tap clears the latch
        tap_ff(10);
        bridge_write(ADDR_FF_SND_EN, 32'd0);
        finish_test(name, start);
    endtask

    task automatic test_video_enable();
        string       name;
        int          start;
        logic [31:0] r;
        logic        exp_de;
        logic [23:0] exp_rgb;
        name = "video_enable";
        start = err_count;
        for (int i = 0; i < 8; i++) begin
            hblank = i[0];
            vblank = i[1];
            r = $urandom;
            rgb_in = r[23:0];
            exp_de  = !(i[0] || i[1]);
            exp_rgb = exp_de ? r[23:0] : 24'd0;
            tick(1);
            if (video_de !== exp_de) begin
                value_error(name, "video_de", $sformatf("%b", exp_de),
                            $sformatf("%b", video_de));
            end
            if (video_rgb !== exp_rgb) begin
                value_error(name, "video_rgb", $sformatf("%h", exp_rgb),
                            $sformatf("%h", video_rgb));
            end
        end
        hblank = 1'b1;
        vblank = 1'b1;
        finish_test(name, start);
    endtask

    task automatic test_video_sync();
        string name;
        int    start;
        name = "video_sync";
        start = err_count;
        vs_in = 1'b1;
        measure_pulse(name, 1'b0, 1);
        vs_in = 1'b0;
        tick(2);
        hs_in = 1'b1;
        measure_pulse(name, 1'b1, 8);
        hs_in = 1'b0;
        tick(2);
        finish_test(name, start);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        void'($urandom(32'h716e));
        err_count = 0;
        test_count = 0;
        failed_tests = 0;
        reset = 1'b1;
        bridge_wr = 1'b0;
        bridge_addr = 32'd0;
        bridge_wr_data = 32'd0;
        dataslot_requestwrite = 1'b0;
        dataslot_requestwrite_id = 16'd0;
        dataslot_allcomplete = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_dout = 16'd0;
        is_gbc_game = 1'b0;
        cont1_key = 32'd0;
        audio_in_l = 16'd0;
        audio_in_r = 16'd0;
        rgb_in = 24'd0;
        hs_in = 1'b0;
        vs_in = 1'b0;
        hblank = 1'b1;
        vblank = 1'b1;
        tick(4);
        reset = 1'b0;
        tick(1);

        test_settings();
        test_host_reset();
        test_palette();
        test_download_model();
        test_ff_tap();
        test_audio_mute();
        test_ff_hold();
        test_video_enable();
        test_video_sync();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tb/gb_core_chk.sv */
// Concurrent checks on the glue outputs, bound into gb_core_top.
// All properties are off while reset is high.

`timescale 1ns/100ps

module gb_core_chk
    import gb_shell_pkg::*;
(
    input logic        clk_sys,
    input logic        reset,
    input logic        core_reset,
    input logic        download_active,
    input logic [15:0] dataslot_requestwrite_id,
    input logic [23:0] video_rgb,
    input logic        video_de,
    input logic        video_hs,
    input logic        video_vs
);

    logic id_is_cart;

    // cart slot taken straight from the raw id bits
    assign id_is_cart = (dataslot_requestwrite_id[5:0] == SLOT_KIND_CART) ||
                        (dataslot_requestwrite_id[7:0] == SLOT_CART_ALT);

    ////////////////////
    // sync pulses
    ////////////////////
    vs_single: assert property (@(posedge clk_sys) disable iff (reset)
        video_vs |=> !video_vs)
        else $error("video_vs high for two cycles in a row");

    hs_single: assert property (@(posedge clk_sys) disable iff (reset)
        video_hs |=> !video_hs)
        else $error("video_hs high for two cycles in a row");

    // blanked pixels must be black
    rgb_blank: assert property (@(posedge clk_sys) disable iff (reset)
        !video_de |-> (video_rgb == 24'd0))
        else $error("video_rgb not zero while video_de is low");

    cart_reset: assert property (@(posedge clk_sys) disable iff (reset)
        (download_active && id_is_cart) |-> core_reset)
        else $error("core_reset low during a cart download");

endmodule

bind gb_core_top gb_core_chk i_gb_core_chk (
    .clk_sys                  (clk_sys),
    .reset                    (reset),
    .core_reset               (core_reset),
    .download_active          (download_active),
    .dataslot_requestwrite_id (dataslot_requestwrite_id),
    .video_rgb                (video_rgb),
    .video_de                 (video_de),
    .video_hs                 (video_hs),
    .video_vs                 (video_vs)
);

/* verilog/gb_core_top.sv */
// Host-side glue around the console core, all on clk_sys.
// The bridge is assumed synchronous to clk_sys.
// core_reset is combinational and should be registered by its user if needed.

`timescale 1ns/100ps

module gb_core_top (
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_addr,
    input  logic [31:0] bridge_wr_data,
    input  logic        dataslot_requestwrite,
    input  logic [15:0] dataslot_requestwrite_id,
    input  logic        dataslot_allcomplete,
    input  logic        ioctl_wr,
    input  logic [15:0] ioctl_dout,
    input  logic        is_gbc_game,
    input  logic [31:0] cont1_key,
    input  logic [15:0] audio_in_l,
    input  logic [15:0] audio_in_r,
    input  logic [23:0] rgb_in,
    input  logic        hs_in,
    input  logic        vs_in,
    input  logic        hblank,
    input  logic        vblank,
    output logic        core_reset,
    output logic        download_active,
    output logic [2:0]  mapper_sel,
    output logic [95:0] palette,
    output logic        is_gbc,
    output logic        megaduck,
    output logic        fast_forward,
    output logic [15:0] audio_out_l,
    output logic [15:0] audio_out_r,
    output logic [23:0] video_rgb,
    output logic        video_de,
    output logic        video_hs,
    output logic        video_vs
);

    logic [1:0] sys_type;
    logic       ff_snd_en;
    logic       host_reset;
    logic       cart_download;
    logic       md_download;
    logic       palette_download;
    logic       boot_download;

    host_config_regs i_host_config_regs (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .bridge_wr      (bridge_wr),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .mapper_sel     (mapper_sel),
        .sys_type       (sys_type),
        .ff_snd_en      (ff_snd_en),
        .host_reset     (host_reset)
    );

    download_decode i_download_decode (
        .clk_sys                  (clk_sys),
        .reset                    (reset),
        .dataslot_requestwrite    (dataslot_requestwrite),
        .dataslot_requestwrite_id (dataslot_requestwrite_id),
        .dataslot_allcomplete     (dataslot_allcomplete),
        .download_active          (download_active),
        .cart_download            (cart_download),
        .md_download              (md_download),
        .palette_download         (palette_download),
        .boot_download            (boot_download)
    );

    // core held in reset while the host loads a cart or boot rom
    assign core_reset = reset | host_reset | cart_download | boot_download;

    palette_store i_palette_store (
        .clk_sys          (clk_sys),
        .reset            (reset),
        .palette_download (palette_download),
        .ioctl_wr         (ioctl_wr),
        .ioctl_dout       (ioctl_dout),
        .palette          (palette)
    );

    model_select i_model_select (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .core_reset    (core_reset),
        .sys_type      (sys_type),
        .cart_download (cart_download),
        .md_download   (md_download),
        .slot_id       (dataslot_requestwrite_id),
        .is_gbc_game   (is_gbc_game),
        .is_gbc        (is_gbc),
        .megaduck      (megaduck)
    );

    // r1 shoulder button drives fast forward
    ff_latch i_ff_latch (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .ff_button       (cont1_key[9]),
        .download_active (download_active),
        .fast_forward    (fast_forward)
    );

    av_output i_av_output (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .fast_forward (fast_forward),
        .ff_snd_en    (ff_snd_en),
        .audio_in_l   (audio_in_l),
        .audio_in_r   (audio_in_r),
        .rgb_in       (rgb_in),
        .hs_in        (hs_in),
        .vs_in        (vs_in),
        .hblank       (hblank),
        .vblank       (vblank),
        .audio_out_l  (audio_out_l),
        .audio_out_r  (audio_out_r),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs)
    );

endmodule

/* verilog/av_output.sv */
// Audio and video shaping towards the scaler.
// Audio is muted during fast forward unless ff_snd_en is set.
// vsync and hsync leave as single-cycle pulses; hsync trails its input
// edge by 8 cycles so it cannot coincide with the vsync pulse.

`timescale 1ns/100ps

module av_output
    import gb_shell_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        fast_forward,
    input  logic        ff_snd_en,
    input  logic [15:0] audio_in_l,
    input  logic [15:0] audio_in_r,
    input  logic [23:0] rgb_in,
    input  logic        hs_in,
    input  logic        vs_in,
    input  logic        hblank,
    input  logic        vblank,
    output logic [15:0] audio_out_l,
    output logic [15:0] audio_out_r,
    output logic [23:0] video_rgb,
    output logic        video_de,
    output logic        video_hs,
    output logic        video_vs
);

    logic       mute;
    logic       de;
    logic       hs_prev;
    logic       vs_prev;
    logic [2:0] hs_delay;

    ////////////////////
    // audio
    ////////////////////
    assign mute = fast_forward & ~ff_snd_en;

    always_ff @(posedge clk_sys) begin
        audio_out_l <= mute ? 16'd0 : audio_in_l;
        audio_out_r <= mute ? 16'd0 : audio_in_r;
    end

    ////////////////////
    // video
    ////////////////////
    assign de = ~(hblank | vblank);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            video_de  <= 1'b0;
            video_rgb <= 24'd0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
            hs_delay  <= 3'd0;
        end else begin
            video_de  <= de;
            // black outside the active area
            video_rgb <= de ? rgb_in : 24'd0;

            video_vs <= vs_in & ~vs_prev;
            video_hs <= (hs_delay == 3'd1);

            if (hs_in && !hs_prev) begin
                hs_delay <= HS_DELAY_CYCLES;
            end else if (hs_delay != 3'd0) begin
                hs_delay <= hs_delay - 3'd1;
            end

            hs_prev <= hs_in;
            vs_prev <= vs_in;
        end
    end

endmodule

/* verilog/ff_latch.sv */
// Fast-forward button handling.
// A short tap latches fast forward on; the next short tap turns it off.
// A long press runs fast forward only while held.
// The button is ignored while a download is in progress.

`timescale 1ns/100ps

module ff_latch
    import gb_shell_pkg::*;
(
    input  logic clk_sys,
    input  logic reset,
    input  logic ff_button,
    input  logic download_active,
    output logic fast_forward
);

    logic        ff_req;
    logic        ff_req_q;
    logic        tap_seen;
    logic        latched;
    logic [31:0] press_count;

    assign ff_req = ff_button & ~download_active;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ff_req_q     <= 1'b0;
            tap_seen     <= 1'b0;
            latched      <= 1'b0;
            press_count  <= 32'd0;
            fast_forward <= 1'b0;
        end else begin
            ff_req_q <= ff_req;

            // saturate so a very long hold never wraps into a tap
            if (ff_req && press_count != 32'hFFFF_FFFF) begin
                press_count <= press_count + 32'd1;
            end

            // press starts
            if (ff_req && !ff_req_q) begin
                press_count <= 32'd0;
                latched     <= 1'b0;
            end

            // release, short first tap latches, second one only clears
            if (!ff_req && ff_req_q) begin
                tap_seen <= 1'b0;
                if (press_count < FF_TAP_CYCLES && !tap_seen) begin
                    tap_seen <= 1'b1;
                    latched  <= 1'b1;
                end
            end

            fast_forward <= ff_req | latched;
        end
    end

endmodule

/* verilog/model_select.sv */
// Picks the console model while the core is held in reset.
// Values hold once core_reset drops; only reset returns them to mono.
// A 0x81 slot decodes as both cart and megaduck, megaduck decode wins.

`timescale 1ns/100ps

module model_select
    import gb_shell_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       core_reset,
    input  logic [1:0] sys_type,
    input  logic       cart_download,
    input  logic       md_download,
    input  slot_id_t   slot_id,
    input  logic       is_gbc_game,
    output logic       is_gbc,
    output logic       megaduck
);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            is_gbc   <= 1'b0;
            megaduck <= 1'b0;
        end else if (core_reset) begin
            if (cart_download) begin
                megaduck <= (sys_type == SYS_MEGADUCK);
            end
            if (md_download) begin
                megaduck <= (sys_type == SYS_AUTO) || (sys_type == SYS_MEGADUCK);
            end

            // forced model from the menu, else guess from the slot
            if (sys_type != SYS_AUTO) begin
                is_gbc <= (sys_type == SYS_GBC);
            end else if (cart_download) begin
                if (slot_id.f.kind == 6'd0) begin
                    is_gbc <= is_gbc_game;
                end else begin
                    is_gbc <= (slot_id.f.flavour == 2'd0);
                end
            end
        end
    end

endmodule

/* download/palette_store.sv */
// Four-colour palette, loaded by a palette download.
// Each ioctl word arrives high byte first and is swapped on entry.
// Only the top 96 bits reach the output.

`timescale 1ns/100ps

module palette_store
    import gb_shell_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        palette_download,
    input  logic        ioctl_wr,
    input  logic [15:0] ioctl_dout,
    output logic [95:0] palette
);

    logic [127:0] pal_q;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pal_q <= PALETTE_DEFAULT;
        end else if (palette_download && ioctl_wr) begin
            pal_q <= {pal_q[111:0], ioctl_dout[7:0], ioctl_dout[15:8]};
        end
    end

    assign palette = pal_q[127:32];

endmodule

/* download/download_decode.sv */
// Tracks the host download window and classifies the slot being written.
// The slot id must stay steady from requestwrite until allcomplete.
// Kind strobes are combinational and only valid while the window is open.
// Border slots (SLOT_BORDER) are not decoded since nothing consumes them.

`timescale 1ns/100ps

module download_decode
    import gb_shell_pkg::*;
(
    input  logic     clk_sys,
    input  logic     reset,
    input  logic     dataslot_requestwrite,
    input  slot_id_t dataslot_requestwrite_id,
    input  logic     dataslot_allcomplete,
    output logic     download_active,
    output logic     cart_download,
    output logic     md_download,
    output logic     palette_download,
    output logic     boot_download
);

    logic is_cart;
    logic is_md;
    logic is_boot;

    // download window, a new request wins over completion
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            download_active <= 1'b0;
        end else if (dataslot_requestwrite) begin
            download_active <= 1'b1;
        end else if (dataslot_allcomplete) begin
            download_active <= 1'b0;
        end
    end

    ////////////////////
    // slot classification
    ////////////////////

    // carts are kind 1 of any flavour, or the alternate 0x80 id
    assign is_cart = (dataslot_requestwrite_id.f.kind == SLOT_KIND_CART) ||
                     (dataslot_requestwrite_id.raw[7:0] == SLOT_CART_ALT);

    // note 0x81 also has kind 1, so it counts as a cart too
    assign is_md = (dataslot_requestwrite_id.raw[7:0] == SLOT_MEGADUCK);

    assign is_boot = (dataslot_requestwrite_id.raw == SLOT_CGB_BOOT) ||
                     (dataslot_requestwrite_id.raw == SLOT_DMG_BOOT) ||
                     (dataslot_requestwrite_id.raw == SLOT_SGB_BOOT);

    assign cart_download    = download_active & is_cart;
    assign md_download      = download_active & is_md;
    assign boot_download    = download_active & is_boot;
    assign palette_download = download_active &
                              (dataslot_requestwrite_id.raw == SLOT_PALETTE);

endmodule

/* verilog/host_config_regs.sv */
// Settings registers written by the host over the bridge.
// Writes to unmapped addresses are ignored; there is no read-back path.
// host_reset stays high for RESET_HOLD_CYCLES after a host reset write,
// and a new write during the hold restarts it.

`timescale 1ns/100ps

module host_config_regs
    import gb_shell_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_addr,
    input  logic [31:0] bridge_wr_data,
    output logic [2:0]  mapper_sel,
    output logic [1:0]  sys_type,
    output logic        ff_snd_en,
    output logic        host_reset
);

    logic [31:0] hold_count;

    ////////////////////
    // settings words
    ////////////////////
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            mapper_sel <= 3'd0;
            sys_type   <= SYS_AUTO;
            ff_snd_en  <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                ADDR_MAPPER_SEL: begin
                    mapper_sel <= bridge_wr_data[2:0];
                end
                ADDR_SYS_TYPE: begin
                    sys_type <= bridge_wr_data[1:0];
                end
                ADDR_FF_SND_EN: begin
                    ff_snd_en <= bridge_wr_data[0];
                end
                default: begin
                    // unmapped, nothing to do
                end
            endcase
        end
    end

    ////////////////////
    // host reset hold
    ////////////////////
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hold_count <= 32'd0;
        end else if (bridge_wr && bridge_addr == ADDR_HOST_RESET) begin
            // data word is don't care, any write starts the hold
            hold_count <= RESET_HOLD_CYCLES;
        end else if (hold_count != 32'd0) begin
            hold_count <= hold_count - 32'd1;
        end
    end

    assign host_reset = (hold_count != 32'd0);

endmodule

/* common/gb_shell_pkg.sv */
// Shared constants and types for the host-side glue of the console core.
// Bridge addresses are byte addresses of 32-bit words on the bridge bus.
// Cycle counts assume the single clk_sys domain.

package gb_shell_pkg;

    ////////////////////
    // bridge register map
    ////////////////////
    localparam logic [31:0] ADDR_HOST_RESET = 32'h0000_0050;
    localparam logic [31:0] ADDR_MAPPER_SEL = 32'h0000_0200;
    localparam logic [31:0] ADDR_SYS_TYPE   = 32'h0000_0208;
    localparam logic [31:0] ADDR_FF_SND_EN  = 32'h0000_020C;

    // host reset hold and fast-forward tap length
    localparam logic [31:0] RESET_HOLD_CYCLES = 32'h0010_0000;
    // about 0.1 s of clk_sys
    localparam logic [31:0] FF_TAP_CYCLES     = 32'd3200000;

    // hsync is pushed late so it never lands on vsync
    localparam logic [2:0]  HS_DELAY_CYCLES = 3'd7;

    // four 24-bit colours in the top 96 bits, low word is padding
    localparam logic [127:0] PALETTE_DEFAULT = 128'h8282_1451_7356_305A_5F1A_3B49_0000_0000;

    ////////////////////
    // data slot ids
    ////////////////////
    localparam logic [15:0] SLOT_BORDER   = 16'd2;
    localparam logic [15:0] SLOT_PALETTE  = 16'd3;
    localparam logic [15:0] SLOT_CGB_BOOT = 16'd4;
    localparam logic [15:0] SLOT_DMG_BOOT = 16'd5;
    localparam logic [15:0] SLOT_SGB_BOOT = 16'd6;

    localparam logic [5:0]  SLOT_KIND_CART = 6'd1;
    localparam logic [7:0]  SLOT_CART_ALT  = 8'h80;
    localparam logic [7:0]  SLOT_MEGADUCK  = 8'h81;

    // sys_type setting codes
    localparam logic [1:0]  SYS_AUTO     = 2'd0;
    localparam logic [1:0]  SYS_GBC      = 2'd2;
    localparam logic [1:0]  SYS_MEGADUCK = 2'd3;

    // slot id, read either whole or as kind and flavour
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [7:0] rsvd;
            logic [1:0] flavour;
            logic [5:0] kind;
        } f;
    } slot_id_t;

endpackage
